// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Datapath widths.
`define FETCH_ADDR_W   64
`define FETCH_INSTR_W  32
`define FETCH_BLOCK_W  512

// Cache and predictor sizes.
`define ICACHE_SETS    16
`define BTB_SETS       8
`define BTB_WAYS       4

// Boot address.
`define FETCH_RESET_PC 64'h8000_0000

// Address splits.
// Byte offset of one instruction word.
`define FETCH_WOFFS_W  $clog2(`FETCH_INSTR_W / 8)
// Byte offset inside one cache block.
`define ICACHE_BOFFS_W $clog2(`FETCH_BLOCK_W / 8)
// Word select inside one cache block.
`define ICACHE_WSEL_W  $clog2(`FETCH_BLOCK_W / `FETCH_INSTR_W)
`define ICACHE_IDX_W   $clog2(`ICACHE_SETS)
`define BTB_IDX_W      $clog2(`BTB_SETS)
`define BTB_WAY_W      $clog2(`BTB_WAYS)

`endif

// File: fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // 2-bit saturating branch counter.
    // Upper half of the range predicts taken.
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } bp_state_e;

    // Fetch result handed to decode.
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0]  pc;
        logic [`FETCH_INSTR_W-1:0] instr;
        logic                      hit;
        logic                      pred_taken;
        logic [`FETCH_ADDR_W-1:0]  pred_target;
        logic                      btb_hit;
        // Hitting way, or the victim way on a miss.
        logic [`BTB_WAY_W-1:0]     btb_way;
    } fetch_out_t;

    // Branch resolution coming back from execute.
    typedef struct packed {
        logic                     valid;
        logic                     taken;
        // Hit and way as reported by fetch for this branch.
        logic                     btb_hit;
        logic [`BTB_WAY_W-1:0]    way;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_ADDR_W-1:0] target;
    } exec_update_t;

    // Corrected fetch address on a mispredict.
    typedef struct packed {
        logic                     mispred;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

endpackage

// File: pc_gen.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_gen (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  fetch_pkg::redirect_t     redirect_i,
    input  logic                     pred_taken_i,
    input  logic [`FETCH_ADDR_W-1:0] pred_target_i,
    output logic [`FETCH_ADDR_W-1:0] pc_o
);

    // Current fetch address.
    logic [`FETCH_ADDR_W-1:0] pc_q;
    // Sequential successor.
    logic [`FETCH_ADDR_W-1:0] pc_plus4;
    // Address loaded on the next accepted edge.
    logic [`FETCH_ADDR_W-1:0] pc_next;

    assign pc_plus4 = pc_q + 64'd4;

    // --------------------------------------
    // Next PC selection.
    // --------------------------------------
    // Execute correction wins over the predictor.
    always_comb begin
        if (redirect_i.mispred) begin
            pc_next = redirect_i.target;
        end else if (pred_taken_i) begin
            pc_next = pred_target_i;
        end else begin
            pc_next = pc_plus4;
        end
    end

    // PC register.
    // Held while stalled, so a pending redirect waits too.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `FETCH_RESET_PC;
        end else if (!stall_i) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: branch_pred_unit.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module branch_pred_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [`FETCH_ADDR_W-1:0]    pc_i,
    input  fetch_pkg::exec_update_t     upd_i,
    output logic                        pred_taken_o,
    output logic [`FETCH_ADDR_W-1:0]    pred_target_o,
    output logic                        btb_hit_o,
    output logic [`BTB_WAY_W-1:0]       way_o
);

    // Set index sits right above the word offset.
    localparam int idx_lo = `FETCH_WOFFS_W;
    localparam int tag_lo = `FETCH_WOFFS_W + `BTB_IDX_W;
    localparam int tag_w  = `FETCH_ADDR_W - tag_lo;

    // BTB storage.
    logic                     valid_q  [`BTB_SETS][`BTB_WAYS];
    logic [tag_w-1:0]         tag_q    [`BTB_SETS][`BTB_WAYS];
    logic [`FETCH_ADDR_W-1:0] target_q [`BTB_SETS][`BTB_WAYS];
    fetch_pkg::bp_state_e     cnt_q    [`BTB_SETS][`BTB_WAYS];
    // Round-robin victim pointer per set.
    logic [`BTB_WAY_W-1:0]    rr_q     [`BTB_SETS];

    // Lookup side.
    logic [`BTB_IDX_W-1:0]    rd_set;
    logic [tag_w-1:0]         rd_tag;
    logic                     rd_hit;
    logic [`BTB_WAY_W-1:0]    rd_way;

    // Training side.
    logic [`BTB_IDX_W-1:0]    up_set;
    logic [tag_w-1:0]         up_tag;
    logic [`BTB_WAY_W-1:0]    up_victim;
    logic                     up_train;
    logic                     up_alloc;

    // One step toward the outcome with saturation at both ends.
    function automatic fetch_pkg::bp_state_e cnt_step(
        input fetch_pkg::bp_state_e cnt,
        input logic                 taken
    );
        fetch_pkg::bp_state_e nxt;
        case (cnt)
            fetch_pkg::strong_nt: nxt = taken ? fetch_pkg::weak_nt  : fetch_pkg::strong_nt;
            fetch_pkg::weak_nt:   nxt = taken ? fetch_pkg::weak_t   : fetch_pkg::strong_nt;
            fetch_pkg::weak_t:    nxt = taken ? fetch_pkg::strong_t : fetch_pkg::weak_nt;
            default:              nxt = taken ? fetch_pkg::strong_t : fetch_pkg::weak_t;
        endcase
        return nxt;
    endfunction

    // --------------------------------------
    // Lookup.
    // --------------------------------------
    assign rd_set = pc_i[idx_lo +: `BTB_IDX_W];
    assign rd_tag = pc_i[`FETCH_ADDR_W-1:tag_lo];

    // Tag compare across all ways with the lowest way first.
    always_comb begin
        rd_hit = 1'b0;
        rd_way = '0;
        for (int w = 0; w < `BTB_WAYS; w++) begin
            if (!rd_hit && valid_q[rd_set][w] && (tag_q[rd_set][w] == rd_tag)) begin
                rd_hit = 1'b1;
                rd_way = w[`BTB_WAY_W-1:0];
            end
        end
    end

    assign btb_hit_o     = rd_hit;
    // On a miss report the way an allocation would take.
    assign way_o         = rd_hit ? rd_way : rr_q[rd_set];
    assign pred_taken_o  = rd_hit && (cnt_q[rd_set][rd_way] inside {fetch_pkg::weak_t,
                                                                    fetch_pkg::strong_t});
    assign pred_target_o = rd_hit ? target_q[rd_set][rd_way] : '0;

    // --------------------------------------
    // Training from execute.
    // --------------------------------------
    assign up_set    = upd_i.pc[idx_lo +: `BTB_IDX_W];
    assign up_tag    = upd_i.pc[`FETCH_ADDR_W-1:tag_lo];
    assign up_victim = rr_q[up_set];
    assign up_train  = upd_i.valid && upd_i.btb_hit;
    // Not-taken misses leave the table alone.
    assign up_alloc  = upd_i.valid && !upd_i.btb_hit && upd_i.taken;

    // Valid bits and victim pointers.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `BTB_SETS; s++) begin
                rr_q[s] <= '0;
                for (int w = 0; w < `BTB_WAYS; w++) begin
                    valid_q[s][w] <= 1'b0;
                end
            end
        end else if (up_alloc) begin
            valid_q[up_set][up_victim] <= 1'b1;
            rr_q[up_set]               <= up_victim + 1'b1;
        end
    end

    // Entry contents.
    always_ff @(posedge clk_i) begin
        if (up_alloc) begin
            tag_q[up_set][up_victim]    <= up_tag;
            target_q[up_set][up_victim] <= upd_i.target;
            cnt_q[up_set][up_victim]    <= fetch_pkg::weak_t;
        end else if (up_train) begin
            cnt_q[up_set][upd_i.way] <= cnt_step(cnt_q[up_set][upd_i.way], upd_i.taken);
            // Target only refreshed by a taken outcome.
            if (upd_i.taken) begin
                target_q[up_set][upd_i.way] <= upd_i.target;
            end
        end
    end

endmodule

// File: icache.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module icache (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`FETCH_ADDR_W-1:0]  addr_i,
    input  logic                      fill_we_i,
    input  logic [`FETCH_BLOCK_W-1:0] fill_block_i,
    output logic [`FETCH_INSTR_W-1:0] instr_o,
    output logic                      hit_o
);

    // Address holds tag, line index, word select and byte offset.
    localparam int tag_lo = `ICACHE_BOFFS_W + `ICACHE_IDX_W;
    localparam int tag_w  = `FETCH_ADDR_W - tag_lo;

    // Line storage.
    logic                      valid_q [`ICACHE_SETS];
    logic [tag_w-1:0]          tag_q   [`ICACHE_SETS];
    logic [`FETCH_BLOCK_W-1:0] data_q  [`ICACHE_SETS];

    // Address fields.
    logic [`ICACHE_WSEL_W-1:0] word_sel;
    logic [`ICACHE_IDX_W-1:0]  line_idx;
    logic [tag_w-1:0]          addr_tag;

    // Read path.
    logic [`FETCH_BLOCK_W-1:0] line_data;
    logic                      hit;

    // --------------------------------------
    // Address split.
    // --------------------------------------
    assign word_sel = addr_i[`FETCH_WOFFS_W +: `ICACHE_WSEL_W];
    assign line_idx = addr_i[`ICACHE_BOFFS_W +: `ICACHE_IDX_W];
    assign addr_tag = addr_i[`FETCH_ADDR_W-1:tag_lo];

    // --------------------------------------
    // Lookup in the same cycle as the PC.
    // --------------------------------------
    assign line_data = data_q[line_idx];
    assign hit       = valid_q[line_idx] && (tag_q[line_idx] == addr_tag);

    // Word select from the block.
    // Zero on a miss.
    assign instr_o = hit ? line_data[word_sel * `FETCH_INSTR_W +: `FETCH_INSTR_W] : '0;
    assign hit_o   = hit;

    // --------------------------------------
    // Fill.
    // --------------------------------------
    // Valid bits.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid_q[s] <= 1'b0;
            end
        end else if (fill_we_i) begin
            valid_q[line_idx] <= 1'b1;
        end
    end

    // Whole block and tag of the current line.
    // Visible to the lookup from the next cycle.
    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            tag_q[line_idx]  <= addr_tag;
            data_q[line_idx] <= fill_block_i;
        end
    end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      stall_fetch_i,
    input  fetch_pkg::redirect_t      redirect_i,
    input  logic                      fill_we_i,
    input  logic [`FETCH_BLOCK_W-1:0] fill_block_i,
    input  fetch_pkg::exec_update_t   exec_upd_i,
    output fetch_pkg::fetch_out_t     fetch_o
);

    // Internal nets.
    logic [`FETCH_ADDR_W-1:0]  pc;
    logic [`FETCH_INSTR_W-1:0] instr;
    logic                      icache_hit;
    logic                      pred_taken;
    logic [`FETCH_ADDR_W-1:0]  pred_target;
    logic                      btb_hit;
    logic [`BTB_WAY_W-1:0]     btb_way;

    // PC register and next-address mux.
    pc_gen pc_gen_i (
        .clk_i         (clk_i        ),
        .rst_n_i       (rst_n_i      ),
        .stall_i       (stall_fetch_i),
        .redirect_i    (redirect_i   ),
        .pred_taken_i  (pred_taken   ),
        .pred_target_i (pred_target  ),
        .pc_o          (pc           )
    );

    // BTB with counters trained by execute.
    branch_pred_unit branch_pred_unit_i (
        .clk_i         (clk_i      ),
        .rst_n_i       (rst_n_i    ),
        .pc_i          (pc         ),
        .upd_i         (exec_upd_i ),
        .pred_taken_o  (pred_taken ),
        .pred_target_o (pred_target),
        .btb_hit_o     (btb_hit    ),
        .way_o         (btb_way    )
    );

    // Instruction cache.
    icache icache_i (
        .clk_i        (clk_i       ),
        .rst_n_i      (rst_n_i     ),
        .addr_i       (pc          ),
        .fill_we_i    (fill_we_i   ),
        .fill_block_i (fill_block_i),
        .instr_o      (instr       ),
        .hit_o        (icache_hit  )
    );

    // --------------------------------------
    // Fetch result.
    // --------------------------------------
    assign fetch_o.pc          = pc;
    assign fetch_o.instr       = instr;
    assign fetch_o.hit         = icache_hit;
    assign fetch_o.pred_taken  = pred_taken;
    assign fetch_o.pred_target = pred_target;
    assign fetch_o.btb_hit     = btb_hit;
    assign fetch_o.btb_way     = btb_way;

endmodule

// File: fetch_stage_props.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage_props (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  stall_fetch_i,
    input fetch_pkg::redirect_t  redirect_i,
    input logic                  fill_we_i,
    input fetch_pkg::fetch_out_t fetch_o
);

    // ----------------------------------------
    // Port level properties of the fetch stage.
    // ----------------------------------------

    // First cycle out of reset shows the boot address.
    boot_pc_a: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> fetch_o.pc == `FETCH_RESET_PC)
        else $error("fetch_o.pc differs from the boot address after reset");

    // Stall freezes the PC and holds off redirects.
    stall_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_fetch_i |=> $stable(fetch_o.pc))
        else $error("fetch_o.pc moved while fetch was stalled");

    // A taken prediction steers the next accepted PC.
    pred_follow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_o.pred_taken && !stall_fetch_i && !redirect_i.mispred
        |=> fetch_o.pc == $past(fetch_o.pred_target))
        else $error("fetch_o.pc did not follow a taken prediction");

    // Filled line hits once the PC was held.
    fill_hit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_we_i && stall_fetch_i |=> fetch_o.hit)
        else $error("no icache hit after a fill with the PC held");

endmodule

// File: fetch_stage_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_stage_tb;

    localparam int n_cycles = 3000;
    localparam int n_br     = 6;
    // Branches all land in BTB set 7, so the set overflows.
    // Last one closes the loop and is always taken.
    localparam logic [63:0] br_pc [n_br] = '{64'h8000_001c, 64'h8000_005c, 64'h8000_009c,
                                             64'h8000_00dc, 64'h8000_011c, 64'h8000_017c};
    localparam logic [63:0] br_tgt [n_br] = '{64'h8000_0040, 64'h8000_0080, 64'h8000_00c0,
                                              64'h8000_0100, 64'h8000_0140, 64'h8000_0000};

    // DUT side.
    logic                      clk;
    logic                      rst_n;
    logic                      stall_fetch;
    fetch_pkg::redirect_t      redirect;
    logic                      fill_we;
    logic [`FETCH_BLOCK_W-1:0] fill_block;
    fetch_pkg::exec_update_t   exec_upd;
    fetch_pkg::fetch_out_t     fetch_out;

    // Reference model state.
    logic [63:0]           m_pc;
    logic                  ic_valid [`ICACHE_SETS];
    logic [63:0]           ic_tag   [`ICACHE_SETS];
    logic                  bt_valid [`BTB_SETS][`BTB_WAYS];
    logic [63:0]           bt_tag   [`BTB_SETS][`BTB_WAYS];
    logic [63:0]           bt_tgt   [`BTB_SETS][`BTB_WAYS];
    fetch_pkg::bp_state_e  bt_cnt   [`BTB_SETS][`BTB_WAYS];
    logic [`BTB_WAY_W-1:0] bt_rr    [`BTB_SETS];

    // Stimulus bookkeeping.
    logic [31:0]           lfsr;
    fetch_pkg::redirect_t  redir_pend;
    int                    br_slot;
    fetch_pkg::fetch_out_t br_seen;
    logic                  cnt_chk;
    logic [`BTB_IDX_W-1:0] cnt_set;
    logic [`BTB_WAY_W-1:0] cnt_way;
    int                    n_checks;
    int                    err_fetch;
    int                    err_pc;
    int                    err_cnt;

    fetch_stage fetch_stage_i (
        .clk_i         (clk        ),
        .rst_n_i       (rst_n      ),
        .stall_fetch_i (stall_fetch),
        .redirect_i    (redirect   ),
        .fill_we_i     (fill_we    ),
        .fill_block_i  (fill_block ),
        .exec_upd_i    (exec_upd   ),
        .fetch_o       (fetch_out  )
    );

    bind fetch_stage fetch_stage_props fetch_stage_props_i (
        .clk_i         (clk_i        ),
        .rst_n_i       (rst_n_i      ),
        .stall_fetch_i (stall_fetch_i),
        .redirect_i    (redirect_i   ),
        .fill_we_i     (fill_we_i    ),
        .fetch_o       (fetch_o      )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // Random bits and memory image.
    // ----------------------------------------
    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic rand_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // Word contents folded from the full word address.
    function automatic logic [31:0] image_word(input logic [63:0] addr);
        logic [31:0] wa;
        wa = addr[33:2] ^ {2'b00, addr[63:34]};
        return (wa * 32'h9e37_79b1) ^ {wa[15:0], wa[31:16]};
    endfunction

    function automatic logic [`FETCH_BLOCK_W-1:0] image_block(input logic [63:0] addr);
        logic [`FETCH_BLOCK_W-1:0] blk;
        logic [63:0]               base;
        base = addr & ~((64'd1 << `ICACHE_BOFFS_W) - 64'd1);
        for (int i = 0; i < `FETCH_BLOCK_W / `FETCH_INSTR_W; i++) begin
            blk[i * `FETCH_INSTR_W +: `FETCH_INSTR_W] = image_word(base + 64'(4 * i));
        end
        return blk;
    endfunction

    function automatic int branch_slot(input logic [63:0] pc);
        for (int i = 0; i < n_br; i++) begin
            if (br_pc[i] == pc) return i;
        end
        return -1;
    endfunction

    // ----------------------------------------
    // Reference model.
    // ----------------------------------------
    task automatic model_reset();
        m_pc = `FETCH_RESET_PC;
        for (int s = 0; s < `ICACHE_SETS; s++) ic_valid[s] = 1'b0;
        for (int s = 0; s < `BTB_SETS; s++) begin
            bt_rr[s] = '0;
            for (int w = 0; w < `BTB_WAYS; w++) bt_valid[s][w] = 1'b0;
        end
    endtask

    // Saturating step toward the outcome.
    function automatic fetch_pkg::bp_state_e count_toward(input fetch_pkg::bp_state_e c,
                                                          input logic taken);
        if (taken && c != fetch_pkg::strong_t) return fetch_pkg::bp_state_e'(c + 2'd1);
        if (!taken && c != fetch_pkg::strong_nt) return fetch_pkg::bp_state_e'(c - 2'd1);
        return c;
    endfunction

    // Outputs expected for the current model PC.
    function automatic fetch_pkg::fetch_out_t expect_fetch();
        fetch_pkg::fetch_out_t    e;
        logic [`ICACHE_IDX_W-1:0] line;
        logic [`BTB_IDX_W-1:0]    set;
        e = '0;
        e.pc = m_pc;
        line = m_pc[`ICACHE_BOFFS_W +: `ICACHE_IDX_W];
        e.hit = ic_valid[line] && (ic_tag[line] == (m_pc >> (`ICACHE_BOFFS_W + `ICACHE_IDX_W)));
        if (e.hit) e.instr = image_word(m_pc);
        set = m_pc[`FETCH_WOFFS_W +: `BTB_IDX_W];
        // Victim way unless a tag matches.
        e.btb_way = bt_rr[set];
        for (int w = 0; w < `BTB_WAYS; w++) begin
            if (!e.btb_hit && bt_valid[set][w]
                && bt_tag[set][w] == (m_pc >> (`FETCH_WOFFS_W + `BTB_IDX_W))) begin
                e.btb_hit = 1'b1;
                e.btb_way = w[`BTB_WAY_W-1:0];
            end
        end
        if (e.btb_hit) begin
            e.pred_target = bt_tgt[set][e.btb_way];
            e.pred_taken  = bt_cnt[set][e.btb_way] inside {fetch_pkg::weak_t, fetch_pkg::strong_t};
        end
        return e;
    endfunction

    // One rising edge with the inputs driven in the last cycle.
    task automatic model_step();
        fetch_pkg::fetch_out_t    e;
        logic [`ICACHE_IDX_W-1:0] line;
        logic [`BTB_IDX_W-1:0]    set;
        logic [`BTB_WAY_W-1:0]    way;
        e = expect_fetch();
        line = m_pc[`ICACHE_BOFFS_W +: `ICACHE_IDX_W];
        br_slot = -1;
        cnt_chk = 1'b0;
        // Accepted and not squashed, so a branch here resolves next cycle.
        if (!stall_fetch && !redirect.mispred) begin
            br_slot = branch_slot(m_pc);
            br_seen = e;
        end
        if (fill_we) begin
            ic_valid[line] = 1'b1;
            ic_tag[line]   = m_pc >> (`ICACHE_BOFFS_W + `ICACHE_IDX_W);
        end
        if (exec_upd.valid) begin
            set = exec_upd.pc[`FETCH_WOFFS_W +: `BTB_IDX_W];
            way = exec_upd.btb_hit ? exec_upd.way : bt_rr[set];
            if (exec_upd.btb_hit) begin
                bt_cnt[set][way] = count_toward(bt_cnt[set][way], exec_upd.taken);
                if (exec_upd.taken) bt_tgt[set][way] = exec_upd.target;
                cnt_chk = 1'b1;
            end else if (exec_upd.taken) begin
                bt_valid[set][way] = 1'b1;
                bt_tag[set][way]   = exec_upd.pc >> (`FETCH_WOFFS_W + `BTB_IDX_W);
                bt_tgt[set][way]   = exec_upd.target;
                bt_cnt[set][way]   = fetch_pkg::weak_t;
                bt_rr[set]         = way + 1'b1;
                cnt_chk = 1'b1;
            end
            cnt_set = set;
            cnt_way = way;
        end
        if (!stall_fetch) begin
            redir_pend = '0;
            m_pc = redirect.mispred ? redirect.target :
                   e.pred_taken     ? e.pred_target   : m_pc + 64'd4;
        end
    endtask

    // Next cycle's inputs chosen from the model state.
    task automatic drive_inputs();
        fetch_pkg::fetch_out_t   e;
        fetch_pkg::exec_update_t upd;
        logic [63:0]             next_ok;
        logic [63:0]             next_pred;
        logic                    taken;
        logic                    lucky;
        upd = '0;
        if (br_slot >= 0) begin
            taken          = (br_slot == n_br - 1) ? 1'b1 : rand_bit();
            upd.valid      = 1'b1;
            upd.taken      = taken;
            upd.btb_hit    = br_seen.btb_hit;
            upd.way        = br_seen.btb_way;
            upd.pc         = br_pc[br_slot];
            upd.target     = br_tgt[br_slot];
            next_ok   = taken ? br_tgt[br_slot] : br_pc[br_slot] + 64'd4;
            next_pred = br_seen.pred_taken ? br_seen.pred_target : br_pc[br_slot] + 64'd4;
            if (next_pred != next_ok) begin
                redir_pend.mispred = 1'b1;
                redir_pend.target  = next_ok;
            end
        end
        e = expect_fetch();
        lucky = rand_bit() & rand_bit() & rand_bit();
        // On a miss hold the PC and supply the block in the same cycle.
        stall_fetch <= !e.hit || lucky;
        fill_we     <= !e.hit;
        fill_block  <= !e.hit ? image_block(m_pc) : '0;
        redirect    <= redir_pend;
        exec_upd    <= upd;
    endtask

    // ----------------------------------------
    // Compare tasks.
    // ----------------------------------------
    task automatic check_pc(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            err_pc++;
        end
    endtask

    task automatic check_counter(input fetch_pkg::bp_state_e got,
                                 input fetch_pkg::bp_state_e exp);
        n_checks++;
        if (got !== exp) begin
            $display("ERR %0t cnt_q got %s exp %s", $time, got.name(), exp.name());
            err_cnt++;
        end
    endtask

    task automatic check_fetch(input fetch_pkg::fetch_out_t got,
                               input fetch_pkg::fetch_out_t exp);
        n_checks++;
        check_pc("fetch_o.pc", got.pc, exp.pc);
        if (got.hit !== exp.hit) begin
            $display("ERR %0t fetch_o.hit got %b exp %b", $time, got.hit, exp.hit);
            err_fetch++;
        end
        if (exp.hit && got.instr !== exp.instr) begin
            $display("ERR %0t fetch_o.instr got %h exp %h", $time, got.instr, exp.instr);
            err_fetch++;
        end
        if (got.btb_hit !== exp.btb_hit || got.btb_way !== exp.btb_way) begin
            $display("ERR %0t fetch_o.btb_hit/btb_way got %b/%0d exp %b/%0d", $time,
                     got.btb_hit, got.btb_way, exp.btb_hit, exp.btb_way);
            err_fetch++;
        end
        if (got.pred_taken !== exp.pred_taken) begin
            $display("ERR %0t fetch_o.pred_taken got %b exp %b", $time,
                     got.pred_taken, exp.pred_taken);
            err_fetch++;
        end
        if (exp.btb_hit) check_pc("fetch_o.pred_target", got.pred_target, exp.pred_target);
    endtask

    // ----------------------------------------
    // Main sequence.
    // ----------------------------------------
    initial begin
        lfsr       = 32'h5346_ee31;
        redir_pend = '0;
        br_slot    = -1;
        cnt_chk    = 1'b0;
        n_checks   = 0;
        err_fetch  = 0;
        err_pc     = 0;
        err_cnt    = 0;
        rst_n       <= 1'b0;
        stall_fetch <= 1'b0;
        redirect    <= '0;
        fill_we     <= 1'b0;
        fill_block  <= '0;
        exec_upd    <= '0;
        model_reset();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        drive_inputs();
        @(negedge clk);
        // Boot address straight out of reset.
        check_pc("fetch_o.pc", fetch_out.pc, `FETCH_RESET_PC);
        repeat (n_cycles) begin
            check_fetch(fetch_out, expect_fetch());
            if (cnt_chk) begin
                check_counter(fetch_stage_i.branch_pred_unit_i.cnt_q[cnt_set][cnt_way],
                              bt_cnt[cnt_set][cnt_way]);
            end
            @(posedge clk);
            model_step();
            drive_inputs();
            @(negedge clk);
        end
        $display("Run done: %0d checks, errors fetch %0d pc %0d counter %0d",
                 n_checks, err_fetch, err_pc, err_cnt);
        if (err_fetch + err_pc + err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog at four times the nominal run length.
    initial begin
        #((n_cycles + 8) * 8 * 4);
        $display("Timeout, the run did not reach its end in time.");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
fetch_pkg.sv
pc_gen.sv
branch_pred_unit.sv
icache.sv
fetch_stage.sv
fetch_stage_props.sv
fetch_stage_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := fetch_stage_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list.
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run, then look for the pass line in the captured output.
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
